/* src/crc24_pkg.sv */
/*
 * CRC24 burst engine shared definitions
 * types, polynomial, initial value, burst limits and the one-bit CRC step
 */
`default_nettype none

package crc24_pkg;

	//////////////////////////////////////////////////
	// widths and limits

	// payload word width in bits
	localparam int word_bits = 64;

	// longest legal burst in words
	localparam int max_burst_words = 3;

	//////////////////////////////////////////////////
	// types

	// one CRC state or one evolved contribution
	typedef logic [23:0] crc24_t;

	// one payload word
	typedef logic [word_bits-1:0] data_word_t;

	// count of older words besides the newest in a burst (0 to 2)
	typedef logic [1:0] burst_cover_t;

	//////////////////////////////////////////////////
	// CRC constants

	// generator polynomial x^24 term implied
	localparam crc24_t crc_poly = 24'h328B63;

	// register value at the start of every burst
	localparam crc24_t crc_init = 24'hFFFFFF;

	//////////////////////////////////////////////////
	// one serial CRC step

	// msb-first shift with no reflection
	// feedback is the outgoing top bit against the incoming data bit
	function automatic crc24_t crc24_bit_step(
		input crc24_t state,
		input logic din
	);
		logic feedback;
		crc24_t next_state;

		feedback = state[23] ^ din;
		next_state = {state[22:0], 1'b0};
		if (feedback) begin
			next_state = next_state ^ crc_poly;
		end
		return next_state;
	endfunction

endpackage

`default_nettype wire

/* src/crc24_zero_advance.sv */
/*
 * CRC24 zero advance
 * moves a CRC state forward through num_words all-zero 64-bit words
 */
`default_nettype none

module crc24_zero_advance #(
	parameter int num_words = 1
) (
	input wire crc24_pkg::crc24_t state,
	output crc24_pkg::crc24_t advanced
);

	import crc24_pkg::*;

	// only advances up to one full burst are meaningful here
	if (num_words < 1 || num_words > max_burst_words) begin : g_range_check
		$error("crc24_zero_advance num_words %0d out of range", num_words);
	end

	//////////////////////////////////////////////////
	// unrolled zero-data shift

	// with din held at zero each step is linear in the state
	// so the loop flattens into a pure XOR network
	always_comb begin : zero_steps
		crc24_t acc;

		acc = state;
		for (int i = 0; i < num_words * word_bits; i++) begin
			acc = crc24_bit_step(acc, 1'b0);
		end
		advanced = acc;
	end

endmodule

`default_nettype wire

/* src/crc24_word_evolve.sv */
/*
 * CRC24 word evolve stage
 * registers the zero-state CRC of each 64-bit word along with its last flag
 */
`default_nettype none

module crc24_word_evolve (
	input wire clk,
	input wire arst,

	// raw payload words in
	input wire word_valid,
	output logic word_ready,
	input wire crc24_pkg::data_word_t word_data,
	input wire word_last,

	// evolved contributions out
	output logic evo_valid,
	input wire evo_ready,
	output crc24_pkg::crc24_t evo_data,
	output logic evo_last
);

	import crc24_pkg::*;

	crc24_t word_evo;
	logic word_take;

	//////////////////////////////////////////////////
	// zero-state CRC of one word

	// msb of the word goes in first
	always_comb begin : evolve_bits
		crc24_t acc;

		acc = '0;
		for (int i = word_bits - 1; i >= 0; i--) begin
			acc = crc24_bit_step(acc, word_data[i]);
		end
		word_evo = acc;
	end

	//////////////////////////////////////////////////
	// single-entry output register

	// room when empty or when the held entry leaves this cycle
	assign word_ready = !evo_valid || evo_ready;
	assign word_take = word_valid && word_ready;

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			evo_valid <= 1'b0;
		end else if (word_ready) begin
			evo_valid <= word_valid;
		end
	end

	// payload follows the handshake
	always_ff @(posedge clk) begin
		if (word_take) begin
			evo_data <= word_evo;
			evo_last <= word_last;
		end
	end

	// upstream must hold a word steady until it is taken
	a_word_stable : assert property (
		@(posedge clk) disable iff (arst)
		word_valid && !word_ready |=> word_valid && $stable(word_data) && $stable(word_last)
	) else $error("word_data changed while waiting for word_ready");

endmodule

`default_nettype wire

/* src/crc24_burst_gather.sv */
/*
 * CRC24 burst gather
 * collects one to three evolved words into a single burst record
 */
`default_nettype none

module crc24_burst_gather (
	input wire clk,
	input wire arst,

	// evolved words from the producer
	input wire evo_valid,
	output logic evo_ready,
	input wire crc24_pkg::crc24_t evo_data,
	input wire evo_last,

	// completed burst record to the consumer
	output logic burst_valid,
	input wire burst_ready,
	output crc24_pkg::crc24_t burst_dat_0,
	output crc24_pkg::crc24_t burst_dat_n1,
	output crc24_pkg::crc24_t burst_dat_n2,
	output crc24_pkg::burst_cover_t burst_cover
);

	import crc24_pkg::*;

	// words already gathered in the open burst
	burst_cover_t word_cnt;
	logic evo_take;
	logic burst_take;

	// the window doubles as the output record
	// so nothing may enter while a finished burst waits
	assign evo_ready = !burst_valid || burst_ready;
	assign evo_take = evo_valid && evo_ready;
	assign burst_take = burst_valid && burst_ready;

	//////////////////////////////////////////////////
	// burst position and record valid

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			word_cnt <= '0;
			burst_valid <= 1'b0;
			burst_cover <= '0;
		end else if (evo_take && evo_last) begin
			// close the burst and start counting afresh
			burst_valid <= 1'b1;
			burst_cover <= word_cnt;
			word_cnt <= '0;
		end else begin
			if (burst_take) begin
				burst_valid <= 1'b0;
			end
			if (evo_take) begin
				word_cnt <= word_cnt + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// three-slot window

	// newest word always lands in slot 0
	// on last the slots outside the burst are zeroed
	always_ff @(posedge clk) begin
		if (evo_take) begin
			burst_dat_0 <= evo_data;
			if (evo_last) begin
				burst_dat_n1 <= (word_cnt >= 2'd1) ? burst_dat_0 : '0;
				burst_dat_n2 <= (word_cnt == 2'd2) ? burst_dat_n1 : '0;
			end else begin
				burst_dat_n1 <= burst_dat_0;
				burst_dat_n2 <= burst_dat_n1;
			end
		end
	end

	// a burst longer than the window would silently drop its oldest word
	a_burst_len : assert property (
		@(posedge clk) disable iff (arst)
		evo_take && (word_cnt == max_burst_words - 1) |-> evo_last
	) else $error("burst longer than %0d words", max_burst_words);

endmodule

`default_nettype wire

/* src/crc24_burst_combine.sv */
/*
 * CRC24 burst combine
 * two-stage pipeline merging evolved words and the evolved initial value
 */
`default_nettype none

module crc24_burst_combine (
	input wire clk,
	input wire arst,

	// burst record from the buffer
	input wire burst_valid,
	output logic burst_ready,
	input wire crc24_pkg::crc24_t burst_dat_0,
	input wire crc24_pkg::crc24_t burst_dat_n1,
	input wire crc24_pkg::crc24_t burst_dat_n2,
	input wire crc24_pkg::burst_cover_t burst_cover,

	// finished burst CRC
	output logic crc_valid,
	input wire crc_ready,
	output crc24_pkg::crc24_t crc
);

	import crc24_pkg::*;

	crc24_t init_adv1;
	crc24_t init_adv2;
	crc24_t init_adv3;
	crc24_t n1_adv1;
	crc24_t n2_adv2;
	crc24_t init_term;
	logic pipe_adv;

	// stage one registers
	logic s1_valid;
	crc24_t s1_dat_0;
	crc24_t s1_n1_term;
	crc24_t s1_init_term;

	//////////////////////////////////////////////////
	// evolved initial value

	// all three fold down to constants
	crc24_zero_advance #(.num_words(1)) u_init_adv1 (.state(crc_init), .advanced(init_adv1));
	crc24_zero_advance #(.num_words(2)) u_init_adv2 (.state(crc_init), .advanced(init_adv2));
	crc24_zero_advance #(.num_words(3)) u_init_adv3 (.state(crc_init), .advanced(init_adv3));

	//////////////////////////////////////////////////
	// older words moved up to the newest position

	crc24_zero_advance #(.num_words(1)) u_n1_adv (.state(burst_dat_n1), .advanced(n1_adv1));
	crc24_zero_advance #(.num_words(2)) u_n2_adv (.state(burst_dat_n2), .advanced(n2_adv2));

	// init goes one word further back than the oldest data word
	// n2 rides along here since it only exists for three-word bursts
	always_comb begin
		case (burst_cover)
			2'd0: init_term = init_adv1;
			2'd1: init_term = init_adv2;
			2'd2: init_term = init_adv3 ^ n2_adv2;
			default: init_term = '0;
		endcase
	end

	//////////////////////////////////////////////////
	// pipeline control

	// both stages move together whenever the output register has room
	assign pipe_adv = !crc_valid || crc_ready;
	assign burst_ready = pipe_adv;

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			s1_valid <= 1'b0;
			crc_valid <= 1'b0;
		end else if (pipe_adv) begin
			s1_valid <= burst_valid;
			crc_valid <= s1_valid;
		end
	end

	// stage one terms
	always_ff @(posedge clk) begin
		if (pipe_adv && burst_valid) begin
			s1_dat_0 <= burst_dat_0;
			s1_n1_term <= (burst_cover != 2'd0) ? n1_adv1 : '0;
			s1_init_term <= init_term;
		end
	end

	// stage two XOR of the three terms
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			crc <= crc_init;
		end else if (pipe_adv && s1_valid) begin
			crc <= s1_dat_0 ^ s1_n1_term ^ s1_init_term;
		end
	end

	// the buffer never forms a record wider than its window
	a_cover_range : assert property (
		@(posedge clk) disable iff (arst)
		burst_valid && burst_ready |-> burst_cover < max_burst_words
	) else $error("burst_cover %0d out of range", burst_cover);

endmodule

`default_nettype wire

/* src/crc24_burst_top.sv */
/*
 * CRC24 burst engine top
 * word evolve, burst gather and burst combine in a valid/ready chain
 */
`default_nettype none

module crc24_burst_top (
	input wire clk,
	input wire arst,

	// payload words
	input wire word_valid,
	output wire word_ready,
	input wire crc24_pkg::data_word_t word_data,
	input wire word_last,

	// one CRC per burst
	output wire crc_valid,
	input wire crc_ready,
	output wire crc24_pkg::crc24_t crc
);

	import crc24_pkg::*;

	//////////////////////////////////////////////////
	// producer to buffer

	wire evo_valid;
	wire evo_ready;
	wire crc24_t evo_data;
	wire evo_last;

	//////////////////////////////////////////////////
	// buffer to consumer

	wire burst_valid;
	wire burst_ready;
	wire crc24_t burst_dat_0;
	wire crc24_t burst_dat_n1;
	wire crc24_t burst_dat_n2;
	wire burst_cover_t burst_cover;

	// per-word zero-state CRC
	crc24_word_evolve u_evolve (
		.clk(clk),
		.arst(arst),
		.word_valid(word_valid),
		.word_ready(word_ready),
		.word_data(word_data),
		.word_last(word_last),
		.evo_valid(evo_valid),
		.evo_ready(evo_ready),
		.evo_data(evo_data),
		.evo_last(evo_last)
	);

	// burst record assembly
	crc24_burst_gather u_gather (
		.clk(clk),
		.arst(arst),
		.evo_valid(evo_valid),
		.evo_ready(evo_ready),
		.evo_data(evo_data),
		.evo_last(evo_last),
		.burst_valid(burst_valid),
		.burst_ready(burst_ready),
		.burst_dat_0(burst_dat_0),
		.burst_dat_n1(burst_dat_n1),
		.burst_dat_n2(burst_dat_n2),
		.burst_cover(burst_cover)
	);

	// final merge
	crc24_burst_combine u_combine (
		.clk(clk),
		.arst(arst),
		.burst_valid(burst_valid),
		.burst_ready(burst_ready),
		.burst_dat_0(burst_dat_0),
		.burst_dat_n1(burst_dat_n1),
		.burst_dat_n2(burst_dat_n2),
		.burst_cover(burst_cover),
		.crc_valid(crc_valid),
		.crc_ready(crc_ready),
		.crc(crc)
	);

endmodule

`default_nettype wire

/* tests/crc24_burst_tb.sv */
/*
 * CRC24 burst engine testbench
 * random bursts from a fixed-seed LCG checked against a serial CRC model
 */
`default_nettype none

module crc24_burst_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import crc24_pkg::*;

	//////////////////////////////////////////////////
	// run constants

	localparam int clk_period = 100;
	localparam int drive_delay = 2;
	localparam int reset_cycles = 3;
	localparam int num_bursts = 300;
	// generous per-burst budget covers gaps and back-pressure
	localparam int timeout_cycles = 20 * num_bursts;
	localparam logic [31:0] lcg_seed = 32'd90;

	// reference CRC parameters for the serial model
	localparam logic [23:0] model_poly = 24'h328B63;
	localparam logic [23:0] model_init = 24'hFFFFFF;

	logic clk;
	logic arst;
	logic word_valid;
	data_word_t word_data;
	logic word_last;
	logic crc_ready;
	wire word_ready;
	wire crc_valid;
	wire crc24_t crc;

	// expected burst CRCs in send order
	crc24_t expected_q[$];
	int bursts_sent = 0;
	int results_seen = 0;
	int cycle_count = 0;
	logic [31:0] stim_rng;
	logic [31:0] ready_rng;

	crc24_burst_top dut0 (
		.clk(clk),
		.arst(arst),
		.word_valid(word_valid),
		.word_ready(word_ready),
		.word_data(word_data),
		.word_last(word_last),
		.crc_valid(crc_valid),
		.crc_ready(crc_ready),
		.crc(crc)
	);

	//////////////////////////////////////////////////
	// helpers

	// 32-bit LCG whose upper bits are the useful ones
	function automatic logic [31:0] lcg_next(input logic [31:0] st);
		return st * 32'd1664525 + 32'd1013904223;
	endfunction

	// one word shifted msb first through a plain serial register
	function automatic crc24_t serial_crc_word(input crc24_t st, input data_word_t d);
		crc24_t acc;
		logic fb;

		acc = st;
		for (int i = 63; i >= 0; i--) begin
			fb = acc[23] ^ d[i];
			acc = {acc[22:0], 1'b0};
			if (fb) begin
				acc = acc ^ model_poly;
			end
		end
		return acc;
	endfunction

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic check_crc(input string name, input crc24_t got, input crc24_t exp);
		if (got !== exp) begin
			fail_run($sformatf("error: %s got %06h expected %06h", name, got, exp));
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			fail_run($sformatf("error: %s got %0h expected %0h", name, got, exp));
		end
	endtask

	// inputs change a little after each rising edge
	task automatic wait_drive_point();
		@(posedge clk);
		#drive_delay;
	endtask

	// hold a word until the producer takes it
	// ready is sampled at the falling edge where everything has settled
	task automatic send_word(input data_word_t data, input logic last);
		logic taken;

		taken = 1'b0;
		word_valid = 1'b1;
		word_data = data;
		word_last = last;
		while (!taken) begin
			@(negedge clk);
			taken = word_ready;
			wait_drive_point();
		end
		word_valid = 1'b0;
	endtask

	//////////////////////////////////////////////////
	// clock and cycle limit

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	initial begin : cycle_limit
		forever begin
			@(posedge clk);
			cycle_count++;
			if (cycle_count > timeout_cycles) begin
				fail_run($sformatf("timeout after %0d cycles, %0d of %0d results seen",
					cycle_count, results_seen, bursts_sent));
			end
		end
	end

	// output back-pressure with ready low about one cycle in three
	initial begin : ready_driver
		ready_rng = lcg_seed ^ 32'h0000A5A5;
		crc_ready = 1'b0;
		forever begin
			wait_drive_point();
			ready_rng = lcg_next(ready_rng);
			crc_ready = (ready_rng[25:16] % 3) != 0;
		end
	end

	//////////////////////////////////////////////////
	// result monitor

	// a stalled result must be the same one on the next cycle
	initial begin : result_monitor
		logic holding;
		crc24_t held_crc;

		holding = 1'b0;
		held_crc = '0;
		forever begin
			@(negedge clk);
			if (arst === 1'b0) begin
				if (holding) begin
					check_flag("crc_valid", crc_valid, 1'b1);
					check_crc("crc held", crc, held_crc);
				end
				holding = 1'b0;
				if (crc_valid === 1'b1) begin
					// nothing may come out before a burst has been completed
					if (expected_q.size() == 0) begin
						fail_run("crc_valid raised with no burst outstanding");
					end
					if (crc_ready) begin
						check_crc("crc", crc, expected_q.pop_front());
						results_seen++;
					end else begin
						holding = 1'b1;
						held_crc = crc;
					end
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// stimulus

	initial begin : stimulus
		int len;
		int gap;
		data_word_t data;
		crc24_t model_state;

		arst = 1'b1;
		word_valid = 1'b0;
		word_data = '0;
		word_last = 1'b0;
		stim_rng = lcg_seed;

		repeat (reset_cycles) @(posedge clk);
		#drive_delay;
		arst = 1'b0;

		// idle state straight after reset
		@(negedge clk);
		check_flag("crc_valid", crc_valid, 1'b0);
		check_flag("word_ready", word_ready, 1'b1);
		check_crc("crc after reset", crc, model_init);
		repeat (4) wait_drive_point();

		for (int b = 0; b < num_bursts; b++) begin
			stim_rng = lcg_next(stim_rng);
			len = 1 + (stim_rng[27:20] % 3);
			model_state = model_init;
			for (int w = 0; w < len; w++) begin
				// occasional idle cycles between words
				stim_rng = lcg_next(stim_rng);
				if (stim_rng[31:29] == 3'd0) begin
					gap = 1 + stim_rng[28];
					repeat (gap) wait_drive_point();
				end
				stim_rng = lcg_next(stim_rng);
				data[63:32] = stim_rng;
				stim_rng = lcg_next(stim_rng);
				data[31:0] = stim_rng;
				model_state = serial_crc_word(model_state, data);
				send_word(data, w == len - 1);
			end
			expected_q.push_back(model_state);
			bursts_sent++;
		end

		// drain and then wait a few quiet cycles for stray results
		while (results_seen < bursts_sent) begin
			wait_drive_point();
		end
		repeat (8) wait_drive_point();

		if (results_seen == bursts_sent && expected_q.size() == 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			fail_run($sformatf("%0d results for %0d bursts, %0d still queued",
				results_seen, bursts_sent, expected_q.size()));
		end
	end

endmodule

`default_nettype wire

/* sources.f */
src/crc24_pkg.sv
src/crc24_zero_advance.sv
src/crc24_word_evolve.sv
src/crc24_burst_gather.sv
src/crc24_burst_combine.sv
src/crc24_burst_top.sv
tests/crc24_burst_tb.sv

/* Bender.yml */
package:
  name: crc24_burst

sources:
  - files:
      - src/crc24_pkg.sv
      - src/crc24_zero_advance.sv
      - src/crc24_word_evolve.sv
      - src/crc24_burst_gather.sv
      - src/crc24_burst_combine.sv
      - src/crc24_burst_top.sv
  - target: test
    files:
      - tests/crc24_burst_tb.sv
